/* hdl/core_pkg.sv */
// shared types and constants for the host glue
//   bridge address map and decoded command
//   setting bits, halfword memory write
//   video word as pixel or end-of-line slot code

package core_pkg;

  //////////////////////////////////////////////////////////////////////
  // bridge side

  typedef logic [31:0] bridge_word_t;
  typedef logic [15:0] half_word_t;
  typedef logic [23:0] load_addr_t;

  // setting registers
  localparam bridge_word_t ADDR_SGX      = 32'h0000_0004;
  localparam bridge_word_t ADDR_RESET    = 32'h0000_0050;
  localparam bridge_word_t ADDR_OVERSCAN = 32'h0000_0100;
  localparam bridge_word_t ADDR_BORDER   = 32'h0000_0104;

  // cartridge image window, upper nibble only
  localparam logic [3:0] LOAD_REGION = 4'h1;

  typedef enum logic [2:0] {
    REG_NONE,
    REG_SGX,
    REG_RESET,
    REG_OVERSCAN,
    REG_BORDER,
    REG_LOAD
  } reg_sel_e;

  typedef struct packed {
    logic       wr;
    logic       rd;
    reg_sel_e   sel;
    load_addr_t load_addr;
    bridge_word_t data;
  } bridge_cmd_t;

  typedef struct packed {
    logic sgx;
    logic overscan;
    logic border;
  } settings_t;

  // core reset hold after a write to the reset register
  localparam int unsigned RESET_COUNT_W = 32;
  localparam logic [RESET_COUNT_W-1:0] RESET_HOLD_DEFAULT = 32'h0010_0000;

  //////////////////////////////////////////////////////////////////////
  // memory side

  typedef struct packed {
    logic       en;
    load_addr_t addr;
    half_word_t data;
  } mem_write_t;

  //////////////////////////////////////////////////////////////////////
  // video side

  typedef logic [1:0] dot_div_t;

  // hsync is moved away from the vsync pulse by this many pixels
  localparam logic [2:0] HS_DELAY_PIX = 3'd6;

  typedef struct packed {
    logic [7:0] r;
    logic [7:0] g;
    logic [7:0] b;
  } pixel_rgb_t;

  // slot code sits in bits 14:13 of the word
  typedef struct packed {
    logic [8:0]  pad_hi;
    logic [1:0]  slot;
    logic [12:0] pad_lo;
  } eol_word_t;

  typedef union packed {
    pixel_rgb_t pixel;
    eol_word_t  eol;
  } video_word_u;

endpackage

/* hdl/bridge_decode.sv */
// bridge strobe register and address classifier
//   produces one decoded command per bridge rd or wr strobe

`timescale 1ns/1ps

module bridge_decode (
  input  logic                   clk_74a,
  input  logic                   pll_core_locked,
  input  core_pkg::bridge_word_t bridge_addr,
  input  core_pkg::bridge_word_t bridge_wr_data,
  input  logic                   bridge_rd,
  input  logic                   bridge_wr,
  output core_pkg::bridge_cmd_t  cmd
);

  core_pkg::reg_sel_e     sel_d;
  core_pkg::reg_sel_e     sel_q;
  logic                   wr_q;
  logic                   rd_q;
  core_pkg::load_addr_t   load_addr_q;
  core_pkg::bridge_word_t data_q;

  // load window wins over the register map
  always_comb begin
    sel_d = core_pkg::REG_NONE;
    if (bridge_addr[31:28] == core_pkg::LOAD_REGION) begin
      sel_d = core_pkg::REG_LOAD;
    end else begin
      case (bridge_addr)
        core_pkg::ADDR_SGX:      sel_d = core_pkg::REG_SGX;
        core_pkg::ADDR_RESET:    sel_d = core_pkg::REG_RESET;
        core_pkg::ADDR_OVERSCAN: sel_d = core_pkg::REG_OVERSCAN;
        core_pkg::ADDR_BORDER:   sel_d = core_pkg::REG_BORDER;
        default:                 sel_d = core_pkg::REG_NONE;
      endcase
    end
  end

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      wr_q  <= 1'b0;
      rd_q  <= 1'b0;
      sel_q <= core_pkg::REG_NONE;
    end else begin
      wr_q  <= bridge_wr;
      rd_q  <= bridge_rd;
      sel_q <= (bridge_wr || bridge_rd) ? sel_d : core_pkg::REG_NONE;
    end
  end

  // payload only, held between strobes
  always_ff @(posedge clk_74a) begin
    if (bridge_wr || bridge_rd) begin
      load_addr_q <= bridge_addr[23:0];
      data_q      <= bridge_wr_data;
    end
  end

  assign cmd = '{wr: wr_q, rd: rd_q, sel: sel_q, load_addr: load_addr_q, data: data_q};

endmodule

/* hdl/settings_regs.sv */
// setting registers with bridge readback
//   sgx, overscan and border bits
//   core reset countdown started by the reset register

`timescale 1ns/1ps

module settings_regs #(
  parameter logic [core_pkg::RESET_COUNT_W-1:0] RESET_HOLD = core_pkg::RESET_HOLD_DEFAULT
) (
  input  logic                   clk_74a,
  input  logic                   pll_core_locked,
  input  core_pkg::bridge_cmd_t  cmd,
  output core_pkg::settings_t    settings,
  output logic                   core_reset_n,
  output core_pkg::bridge_word_t bridge_rd_data
);

  logic [core_pkg::RESET_COUNT_W-1:0] reset_cnt;
  logic                               rd_bit;

  // readback picks the addressed bit, zero elsewhere
  always_comb begin
    case (cmd.sel)
      core_pkg::REG_SGX:      rd_bit = settings.sgx;
      core_pkg::REG_OVERSCAN: rd_bit = settings.overscan;
      core_pkg::REG_BORDER:   rd_bit = settings.border;
      default:                rd_bit = 1'b0;
    endcase
  end

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      settings       <= '0;
      reset_cnt      <= '0;
      bridge_rd_data <= '0;
    end else begin
      if (reset_cnt != '0) begin
        reset_cnt <= reset_cnt - core_pkg::RESET_COUNT_W'(1);
      end

      if (cmd.wr) begin
        case (cmd.sel)
          core_pkg::REG_SGX:      settings.sgx      <= cmd.data[0];
          core_pkg::REG_OVERSCAN: settings.overscan <= cmd.data[0];
          core_pkg::REG_BORDER:   settings.border   <= cmd.data[0];
          // retrigger restarts the full hold
          core_pkg::REG_RESET:    reset_cnt         <= RESET_HOLD;
          default: ;
        endcase
      end

      if (cmd.rd) begin
        bridge_rd_data <= {31'd0, rd_bit};
      end
    end
  end

  // low for exactly RESET_HOLD cycles after the command
  assign core_reset_n = (reset_cnt == '0);

endmodule

/* hdl/rom_loader.sv */
// cartridge image loader
//   two-entry queue of bridge words
//   each word leaves as two halfword writes, upper half first
//   memory side is valid/ready, overflow flag sticks until reset

`timescale 1ns/1ps

module rom_loader (
  input  logic                  clk_74a,
  input  logic                  pll_core_locked,
  input  core_pkg::bridge_cmd_t cmd,
  input  logic                  mem_ready,
  output core_pkg::mem_write_t  mem_wr,
  output logic                  loader_overflow
);

  core_pkg::bridge_word_t word_q [2];
  core_pkg::load_addr_t   addr_q [2];

  logic [1:0] count;
  logic       wr_ptr;
  logic       rd_ptr;
  logic       half_sel;
  logic       load_cmd;
  logic       full;
  logic       push;
  logic       drop;
  logic       take;
  logic       pop;

  assign load_cmd = cmd.wr && (cmd.sel == core_pkg::REG_LOAD);
  assign full     = (count == 2'd2);
  assign push     = load_cmd && !full;
  assign drop     = load_cmd && full;

  // a halfword is taken whenever the head is valid and memory is ready
  assign take = mem_ready && (count != 2'd0);
  // second half done frees the slot
  assign pop  = take && half_sel;

  //////////////////////////////////////////////////////////////////////
  // word storage

  always_ff @(posedge clk_74a) begin
    if (push) begin
      word_q[wr_ptr] <= cmd.data;
      addr_q[wr_ptr] <= cmd.load_addr;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // queue control

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      count           <= 2'd0;
      wr_ptr          <= 1'b0;
      rd_ptr          <= 1'b0;
      half_sel        <= 1'b0;
      loader_overflow <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr <= ~wr_ptr;
      end
      if (take) begin
        half_sel <= ~half_sel;
      end
      if (pop) begin
        rd_ptr <= ~rd_ptr;
      end

      case ({push, pop})
        2'b10:   count <= count + 2'd1;
        2'b01:   count <= count - 2'd1;
        default: count <= count;
      endcase

      if (drop) begin
        loader_overflow <= 1'b1;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // memory write, big-endian bridge so the upper half goes first

  always_comb begin
    mem_wr.en = take;
    if (half_sel) begin
      mem_wr.addr = addr_q[rd_ptr] + core_pkg::load_addr_t'(2);
      mem_wr.data = word_q[rd_ptr][15:0];
    end else begin
      mem_wr.addr = addr_q[rd_ptr];
      mem_wr.data = word_q[rd_ptr][31:16];
    end
  end

endmodule

/* hdl/video_output.sv */
// video output conditioning
//   data enable from the blanking inputs
//   single pixel vsync pulse and delayed hsync
//   end-of-line slot word after the last active pixel

`timescale 1ns/1ps

module video_output (
  input  logic                  clk_74a,
  input  logic                  pll_core_locked,
  input  logic                  pix_ce,
  input  logic                  hblank,
  input  logic                  vblank,
  input  logic                  hsync_core,
  input  logic                  vsync_core,
  input  core_pkg::pixel_rgb_t  rgb_core,
  input  core_pkg::dot_div_t    dot_div,
  output core_pkg::video_word_u video_rgb,
  output logic                  video_de,
  output logic                  video_hs,
  output logic                  video_vs
);

  logic       hs_prev;
  logic       vs_prev;
  logic       de_prev;
  logic [2:0] hs_delay;
  logic [1:0] slot;

  assign video_de = !(hblank || vblank);

  // high from the vsync rise until the next pixel samples it
  assign video_vs = vsync_core && !vs_prev;
  assign video_hs = (hs_delay == 3'd1);

  // divider codes 2 and 3 share the fastest dot clock
  assign slot = (dot_div > 2'd1) ? 2'd2 : dot_div;

  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      hs_prev  <= 1'b0;
      vs_prev  <= 1'b0;
      de_prev  <= 1'b0;
      hs_delay <= 3'd0;
    end else if (pix_ce) begin
      if (hsync_core && !hs_prev) begin
        hs_delay <= core_pkg::HS_DELAY_PIX;
      end else if (hs_delay != 3'd0) begin
        hs_delay <= hs_delay - 3'd1;
      end
      hs_prev <= hsync_core;
      vs_prev <= vsync_core;
      de_prev <= video_de;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // rgb word: pixel, slot code on the first blank pixel, else zero

  always_comb begin
    video_rgb = '0;
    if (video_de) begin
      video_rgb.pixel = rgb_core;
    end else if (de_prev) begin
      video_rgb.eol.slot = slot;
    end
  end

endmodule

/* hdl/core_top.sv */
// host glue top level
//   bridge decode feeding settings and the rom loader
//   video output conditioning for the scaler

`timescale 1ns/1ps

module core_top #(
  parameter logic [core_pkg::RESET_COUNT_W-1:0] RESET_HOLD = core_pkg::RESET_HOLD_DEFAULT
) (
  input  logic                   clk_74a,
  input  logic                   pll_core_locked,
  // bridge
  input  core_pkg::bridge_word_t bridge_addr,
  input  logic                   bridge_rd,
  input  logic                   bridge_wr,
  input  core_pkg::bridge_word_t bridge_wr_data,
  output core_pkg::bridge_word_t bridge_rd_data,
  // settings and core reset
  output core_pkg::settings_t    settings,
  output logic                   core_reset_n,
  // rom memory
  input  logic                   mem_ready,
  output core_pkg::mem_write_t   mem_wr,
  output logic                   loader_overflow,
  // video from the console core
  input  logic                   pix_ce,
  input  logic                   hblank,
  input  logic                   vblank,
  input  logic                   hsync_core,
  input  logic                   vsync_core,
  input  core_pkg::pixel_rgb_t   rgb_core,
  input  core_pkg::dot_div_t     dot_div,
  // video to the scaler
  output core_pkg::video_word_u  video_rgb,
  output logic                   video_de,
  output logic                   video_hs,
  output logic                   video_vs
);

  core_pkg::bridge_cmd_t cmd;

  bridge_decode u_bridge_decode (
    .clk_74a        (clk_74a),
    .pll_core_locked(pll_core_locked),
    .bridge_addr    (bridge_addr),
    .bridge_wr_data (bridge_wr_data),
    .bridge_rd      (bridge_rd),
    .bridge_wr      (bridge_wr),
    .cmd            (cmd)
  );

  settings_regs #(
    .RESET_HOLD(RESET_HOLD)
  ) u_settings_regs (
    .clk_74a        (clk_74a),
    .pll_core_locked(pll_core_locked),
    .cmd            (cmd),
    .settings       (settings),
    .core_reset_n   (core_reset_n),
    .bridge_rd_data (bridge_rd_data)
  );

  rom_loader u_rom_loader (
    .clk_74a        (clk_74a),
    .pll_core_locked(pll_core_locked),
    .cmd            (cmd),
    .mem_ready      (mem_ready),
    .mem_wr         (mem_wr),
    .loader_overflow(loader_overflow)
  );

  video_output u_video_output (
    .clk_74a        (clk_74a),
    .pll_core_locked(pll_core_locked),
    .pix_ce         (pix_ce),
    .hblank         (hblank),
    .vblank         (vblank),
    .hsync_core     (hsync_core),
    .vsync_core     (vsync_core),
    .rgb_core       (rgb_core),
    .dot_div        (dot_div),
    .video_rgb      (video_rgb),
    .video_de       (video_de),
    .video_hs       (video_hs),
    .video_vs       (video_vs)
  );

endmodule

/* verification/core_top_properties.sv */
// concurrent checks on the rom loader and video outputs
//   bound into the top level next to both instances

`timescale 1ns/1ps

module core_top_properties (
  input logic                 clk_74a,
  input logic                 pll_core_locked,
  input logic                 mem_ready,
  input core_pkg::mem_write_t mem_wr,
  input logic                 pix_ce,
  input logic                 hsync_core,
  input logic                 video_vs,
  input logic                 video_hs
);

  logic vs_last_ce;
  logic hs_last_ce;
  logic hs_rise_seen;

  // history sampled on pixel strobes only
  always_ff @(posedge clk_74a or negedge pll_core_locked) begin
    if (!pll_core_locked) begin
      vs_last_ce   <= 1'b0;
      hs_last_ce   <= 1'b0;
      hs_rise_seen <= 1'b0;
    end else if (pix_ce) begin
      vs_last_ce <= video_vs;
      hs_last_ce <= hsync_core;
      if (hsync_core && !hs_last_ce) begin
        hs_rise_seen <= 1'b1;
      end
    end
  end

  write_needs_ready: assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
    mem_wr.en |-> mem_ready)
    else $error("mem_wr.en high while mem_ready is low");

  vs_single_pixel: assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
    (pix_ce && video_vs) |-> !vs_last_ce)
    else $error("video_vs high on two pixel strobes in a row");

  hs_quiet_until_rise: assert property (@(posedge clk_74a) disable iff (!pll_core_locked)
    !hs_rise_seen |-> !video_hs)
    else $error("video_hs high before any hsync rise");

endmodule

bind core_top core_top_properties u_properties (
  .clk_74a(clk_74a), .pll_core_locked(pll_core_locked), .mem_ready(mem_ready),
  .mem_wr(mem_wr), .pix_ce(pix_ce), .hsync_core(hsync_core),
  .video_vs(video_vs), .video_hs(video_hs)
);

/* verification/core_top_tb.sv */
// testbench for the host glue top level
//   directed tests for settings, core reset, rom loader and video output
//   error count and summary line at the end

`timescale 1ns/1ps

module core_top_tb;

  localparam logic [31:0] HOLD_CYCLES = 32'd40;
  localparam int CLK_NS = 20;
  // cycle budget per test
  localparam int SETTINGS_CYCLES = 80;
  localparam int RESET_CYCLES = 80;
  localparam int LOAD_CYCLES = 80;
  localparam int BURST_CYCLES = 300;
  localparam int VIDEO_CYCLES = 4 * 24 * 2 + 20;
  localparam int WATCHDOG_CYCLES = 5 + SETTINGS_CYCLES + RESET_CYCLES + LOAD_CYCLES
                                   + BURST_CYCLES + VIDEO_CYCLES + 200;

  logic                   clk_74a;
  logic                   pll_core_locked;
  core_pkg::bridge_word_t bridge_addr;
  logic                   bridge_rd;
  logic                   bridge_wr;
  core_pkg::bridge_word_t bridge_wr_data;
  core_pkg::bridge_word_t bridge_rd_data;
  core_pkg::settings_t    settings;
  logic                   core_reset_n;
  logic                   mem_ready;
  core_pkg::mem_write_t   mem_wr;
  logic                   loader_overflow;
  logic                   pix_ce;
  logic                   hblank;
  logic                   vblank;
  logic                   hsync_core;
  logic                   vsync_core;
  core_pkg::pixel_rgb_t   rgb_core;
  core_pkg::dot_div_t     dot_div;
  core_pkg::video_word_u  video_rgb;
  logic                   video_de;
  logic                   video_hs;
  logic                   video_vs;

  integer      seed;
  int          errors;
  int          checks;
  logic        random_ready;
  logic [2:0]  exp_settings;
  logic [23:0] got_addr [$];
  logic [15:0] got_data [$];
  logic [23:0] exp_addr [$];
  logic [15:0] exp_data [$];
  // video reference state, one update per pixel strobe
  logic        last_de;
  logic        last_vs;
  logic        last_hs;
  int          since_hs_rise;
  int          vs_pulses;

  core_top #(
    .RESET_HOLD(HOLD_CYCLES)
  ) UUT (
    .clk_74a(clk_74a), .pll_core_locked(pll_core_locked),
    .bridge_addr(bridge_addr), .bridge_rd(bridge_rd), .bridge_wr(bridge_wr),
    .bridge_wr_data(bridge_wr_data), .bridge_rd_data(bridge_rd_data),
    .settings(settings), .core_reset_n(core_reset_n),
    .mem_ready(mem_ready), .mem_wr(mem_wr), .loader_overflow(loader_overflow),
    .pix_ce(pix_ce), .hblank(hblank), .vblank(vblank), .hsync_core(hsync_core),
    .vsync_core(vsync_core), .rgb_core(rgb_core), .dot_div(dot_div),
    .video_rgb(video_rgb), .video_de(video_de), .video_hs(video_hs), .video_vs(video_vs)
  );

  initial begin
    clk_74a = 1'b0;
    forever #(CLK_NS / 2) clk_74a = ~clk_74a;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_NS);
    $display("watchdog expired before the tests finished");
    $display("SOME TESTS FAILED");
    $finish;
  end

  // memory handshake sampled mid-cycle, taken at the next rising edge
  always @(negedge clk_74a) begin
    if (pll_core_locked && mem_wr.en && mem_ready) begin
      got_addr.push_back(mem_wr.addr);
      got_data.push_back(mem_wr.data);
    end
  end

  always @(posedge clk_74a) begin
    #2;
    if (random_ready) begin
      mem_ready = 1'($random(seed));
    end
  end

  //////////////////////////////////////////////////////////////////////
  // helpers

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("Fail %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_true(input logic cond, input string what);
    checks++;
    assert (cond) else begin
      errors++;
      $display("%s", what);
    end
  endtask

  task automatic bridge_write(input logic [31:0] addr, input logic [31:0] data);
    @(posedge clk_74a);
    #2;
    bridge_addr    = addr;
    bridge_wr_data = data;
    bridge_wr      = 1'b1;
    @(posedge clk_74a);
    #2;
    bridge_wr = 1'b0;
  endtask

  // read data is registered two cycles after the strobe
  task automatic bridge_read(input logic [31:0] addr, output logic [31:0] data);
    @(posedge clk_74a);
    #2;
    bridge_addr = addr;
    bridge_rd   = 1'b1;
    @(posedge clk_74a);
    #2;
    bridge_rd = 1'b0;
    @(posedge clk_74a);
    #1;
    data = bridge_rd_data;
  endtask

  task automatic write_and_check(input logic [31:0] addr, input int bit_idx, input logic val);
    logic [31:0] data;
    logic [31:0] rd;
    data      = $random(seed);
    data[0]   = val;
    exp_settings[bit_idx] = val;
    bridge_write(addr, data);
    bridge_read(addr, rd);
    check_value("bridge_rd_data", rd, {31'd0, val});
    check_value("settings", settings, exp_settings);
  endtask

  // big-endian bridge: upper half lands at the offset
  task automatic send_word(input logic [23:0] offset, input logic [31:0] data,
                           input logic expect_it);
    if (expect_it) begin
      exp_addr.push_back(offset);
      exp_data.push_back(data[31:16]);
      exp_addr.push_back(offset + 24'd2);
      exp_data.push_back(data[15:0]);
    end
    bridge_write({8'h10, offset}, data);
  endtask

  task automatic wait_writes(input int count, input int limit);
    int waited;
    waited = 0;
    while (got_addr.size() < count && waited < limit) begin
      @(posedge clk_74a);
      waited++;
    end
    check_true(got_addr.size() >= count, "memory writes did not arrive in time");
  endtask

  task automatic compare_writes;
    check_value("mem_wr count", got_addr.size(), exp_addr.size());
    for (int i = 0; i < exp_addr.size() && i < got_addr.size(); i++) begin
      check_value("mem_wr.addr", got_addr[i], exp_addr[i]);
      check_value("mem_wr.data", got_data[i], exp_data[i]);
    end
    got_addr.delete();
    got_data.delete();
    exp_addr.delete();
    exp_data.delete();
  endtask

  task automatic pixel_step(input logic hb, input logic vb, input logic hs, input logic vs);
    logic [23:0] rgb;
    logic        exp_de;
    logic [1:0]  exp_slot;
    logic [23:0] exp_rgb;
    rgb = 24'($random(seed));
    @(posedge clk_74a);
    #2;
    pix_ce     = 1'b1;
    hblank     = hb;
    vblank     = vb;
    hsync_core = hs;
    vsync_core = vs;
    rgb_core   = rgb;
    #3;
    exp_de   = !(hb || vb);
    exp_slot = (dot_div == 2'd0) ? 2'd0 : ((dot_div == 2'd1) ? 2'd1 : 2'd2);
    if (exp_de) begin
      exp_rgb = rgb;
    end else if (last_de) begin
      exp_rgb = {9'd0, exp_slot, 13'd0};
    end else begin
      exp_rgb = 24'd0;
    end
    check_value("video_de", video_de, exp_de);
    check_value("video_vs", video_vs, vs && !last_vs);
    check_value("video_hs", video_hs, since_hs_rise == 5);
    check_value("video_rgb", video_rgb, exp_rgb);
    if (video_vs) begin
      vs_pulses++;
    end
    if (hs && !last_hs) begin
      since_hs_rise = 0;
    end else if (since_hs_rise >= 0) begin
      since_hs_rise++;
    end
    last_de = exp_de;
    last_vs = vs;
    last_hs = hs;
    @(posedge clk_74a);
    #2;
    pix_ce = 1'b0;
  endtask

  // 24 pixels: active 8..19, hsync at 2..4
  task automatic video_line(input logic [1:0] dd, input logic vb, input int vs_steps);
    dot_div = dd;
    for (int j = 0; j < 24; j++) begin
      pixel_step(j < 8 || j >= 20, vb, j >= 2 && j < 5, j < vs_steps);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // directed tests

  task automatic test_settings;
    logic [31:0] rd;
    write_and_check(core_pkg::ADDR_SGX, 2, 1'b1);
    write_and_check(core_pkg::ADDR_OVERSCAN, 1, 1'b1);
    write_and_check(core_pkg::ADDR_BORDER, 0, 1'b1);
    bridge_read(32'h0000_0200, rd);
    check_value("bridge_rd_data", rd, 32'd0);
    bridge_read(core_pkg::ADDR_RESET, rd);
    check_value("bridge_rd_data", rd, 32'd0);
    write_and_check(core_pkg::ADDR_SGX, 2, 1'b0);
    write_and_check(core_pkg::ADDR_BORDER, 0, 1'b0);
    // sgx low, the other two high, so each readback bit is told apart
    write_and_check(core_pkg::ADDR_BORDER, 0, 1'b1);
    bridge_read(core_pkg::ADDR_OVERSCAN, rd);
    check_value("bridge_rd_data", rd, {31'd0, exp_settings[1]});
  endtask

  task automatic test_core_reset;
    int waited;
    int low_cycles;
    bridge_write(core_pkg::ADDR_RESET, 32'h1);
    waited = 0;
    while (core_reset_n && waited < 10) begin
      @(posedge clk_74a);
      #1;
      waited++;
    end
    check_true(!core_reset_n, "core_reset_n did not go low after the reset write");
    low_cycles = 0;
    while (!core_reset_n && low_cycles < 200) begin
      low_cycles++;
      @(posedge clk_74a);
      #1;
    end
    check_value("core_reset_n low cycles", low_cycles, HOLD_CYCLES);
  endtask

  task automatic test_load_order;
    logic [23:0] offset;
    logic [31:0] data;
    mem_ready = 1'b1;
    for (int i = 0; i < 6; i++) begin
      offset = 24'($random(seed)) & 24'hff_fffc;
      data   = $random(seed);
      send_word(offset, data, 1'b1);
      @(posedge clk_74a);
    end
    wait_writes(12, 40);
    repeat (3) @(posedge clk_74a);
    #1;
    compare_writes();
    check_value("loader_overflow", loader_overflow, 1'b0);
  endtask

  task automatic test_load_burst;
    logic [31:0] words [5];
    logic [23:0] offs [5];
    for (int i = 0; i < 5; i++) begin
      words[i] = $random(seed);
      offs[i]  = 24'($random(seed)) & 24'hff_fffc;
    end
    random_ready = 1'b1;
    send_word(offs[0], words[0], 1'b1);
    send_word(offs[1], words[1], 1'b1);
    wait_writes(4, 200);
    random_ready = 1'b0;
    @(posedge clk_74a);
    #2;
    mem_ready = 1'b0;
    repeat (2) @(posedge clk_74a);
    #1;
    compare_writes();
    check_value("loader_overflow", loader_overflow, 1'b0);
    // memory stalled, so the third word meets a full queue
    send_word(offs[2], words[2], 1'b1);
    send_word(offs[3], words[3], 1'b1);
    send_word(offs[4], words[4], 1'b0);
    repeat (3) @(posedge clk_74a);
    #1;
    check_value("loader_overflow", loader_overflow, 1'b1);
    check_value("mem_wr count", got_addr.size(), 0);
    #1;
    mem_ready = 1'b1;
    wait_writes(4, 40);
    repeat (4) @(posedge clk_74a);
    compare_writes();
  endtask

  task automatic test_video;
    vs_pulses = 0;
    video_line(2'd0, 1'b0, 4);
    video_line(2'd1, 1'b0, 0);
    video_line(2'd3, 1'b0, 4);
    video_line(2'd0, 1'b1, 0);
    check_value("video_vs pulses", vs_pulses, 2);
  endtask

  //////////////////////////////////////////////////////////////////////
  // main sequence

  initial begin
    seed            = 32'h47e5_8bc5;
    errors          = 0;
    checks          = 0;
    random_ready    = 1'b0;
    exp_settings    = 3'b000;
    last_de         = 1'b0;
    last_vs         = 1'b0;
    last_hs         = 1'b0;
    since_hs_rise   = -1;
    pll_core_locked = 1'b0;
    bridge_addr     = '0;
    bridge_rd       = 1'b0;
    bridge_wr       = 1'b0;
    bridge_wr_data  = '0;
    mem_ready       = 1'b0;
    pix_ce          = 1'b0;
    hblank          = 1'b1;
    vblank          = 1'b1;
    hsync_core      = 1'b0;
    vsync_core      = 1'b0;
    rgb_core        = '0;
    dot_div         = 2'd0;
    repeat (5) @(posedge clk_74a);
    #2;
    pll_core_locked = 1'b1;

    test_settings();
    test_core_reset();
    test_load_order();
    test_load_burst();
    test_video();

    $display("summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

/* sources.f */
hdl/core_pkg.sv
hdl/bridge_decode.sv
hdl/settings_regs.sv
hdl/rom_loader.sv
hdl/video_output.sv
hdl/core_top.sv
verification/core_top_properties.sv
verification/core_top_tb.sv

/* Bender.yml */
package:
  name: core_glue

sources:
  - hdl/core_pkg.sv
  - hdl/bridge_decode.sv
  - hdl/settings_regs.sv
  - hdl/rom_loader.sv
  - hdl/video_output.sv
  - hdl/core_top.sv
  - target: test
    files:
      - verification/core_top_properties.sv
      - verification/core_top_tb.sv
